// File: build.f
common/tetris_pkg.sv
hw/vga_timing.sv
hw/pixel_render.sv
hw/game_control.sv
piece/piece_mover.sv
playfield/playfield_store.sv
hw/tetris_top.sv
verification/tetris_properties.sv
verification/tetris_tb.sv

// File: common/tetris_pkg.sv
package tetris_pkg;

    localparam int BOARD_COLS = 16;                   // Playfield width in cells
    localparam int BOARD_ROWS = 15;                   // Playfield height in cells

    typedef logic [3:0] col_t;                        // Board column
    typedef logic [3:0] row_t;                        // Board row
    typedef logic [1:0] rot_t;                        // Quarter turns
    typedef logic [2:0] colour_t;                     // Palette index, 0 is empty
    typedef logic [9:0] coord_t;                      // Pixel or line number
    typedef logic [15:0] shape_mask_t;                // 4x4 cells, MSB is top-left

    localparam col_t SPAWN_COL = 4'd6;                // New pieces enter here at row 0

    // Spawn order, doubles as the colour number of each piece
    typedef enum logic [2:0] {
        PK_I = 3'd1, PK_O, PK_T, PK_S, PK_Z, PK_J, PK_L
    } piece_kind_e;

    typedef enum logic [1:0] {CMD_LEFT, CMD_RIGHT, CMD_ROT, CMD_DOWN} cmd_e;

    typedef enum logic [2:0] {
        OP_NONE, OP_SPAWN, OP_LEFT, OP_RIGHT, OP_ROT, OP_DOWN
    } mover_op_e;

    typedef logic [BOARD_COLS-1:0] board_row_t;       // Bit n is column n
    typedef board_row_t [BOARD_ROWS-1:0] board_t;     // Row 0 is the top

    typedef struct packed {
        piece_kind_e kind;
        rot_t        rot;
        col_t        col;                             // Left edge of the 4x4 box
        row_t        row;                             // Top edge of the 4x4 box
    } piece_state_s;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_s;

    typedef struct packed {
        logic       hs;                               // Active low
        logic       vs;                               // Active low
        logic       active;
        pixel_pos_s pos;
    } vga_beat_s;

    typedef struct packed {
        logic       hs;
        logic       vs;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } vga_out_s;

    // Four rotations per kind, kinds in spawn order
    localparam shape_mask_t SHAPE_TABLE [28] = '{
        16'hF000, 16'h8888, 16'hF000, 16'h8888,       // I
        16'hCC00, 16'hCC00, 16'hCC00, 16'hCC00,       // O
        16'hE400, 16'h4C40, 16'h4E00, 16'h8C80,       // T
        16'h6C00, 16'h8C40, 16'h6C00, 16'h8C40,       // S
        16'hC600, 16'h4C80, 16'hC600, 16'h4C80,       // Z
        16'h8E00, 16'hC880, 16'hE200, 16'h44C0,       // J
        16'h2E00, 16'h88C0, 16'hE800, 16'hC440        // L
    };

    function automatic shape_mask_t shape_of(piece_kind_e kind, rot_t rot);
        logic [4:0] idx;
        idx = {3'(kind) - 3'd1, rot};                 // Four entries per kind
        return (3'(kind) == 3'd0) ? '0 : SHAPE_TABLE[idx];
    endfunction

    function automatic logic shape_bit(shape_mask_t m, logic [1:0] r, logic [1:0] c);
        return m[4'd15 - {r, c}];
    endfunction

    // Piece cells that land inside the field, as a board overlay
    function automatic board_t piece_cells(piece_state_s p);
        shape_mask_t m;
        logic [4:0]  r_abs;
        logic [4:0]  c_abs;
        board_t      cells;
        m     = shape_of(p.kind, p.rot);
        cells = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                r_abs = {1'b0, p.row} + 5'(r);
                c_abs = {1'b0, p.col} + 5'(c);
                if (shape_bit(m, 2'(r), 2'(c)) && r_abs < BOARD_ROWS && c_abs < BOARD_COLS)
                    cells[r_abs[3:0]][c_abs[3:0]] = 1'b1;
            end
        end
        return cells;
    endfunction

    // Low if any occupied cell hangs past the right or bottom edge
    function automatic logic piece_inside(piece_state_s p);
        shape_mask_t m;
        logic        ok;
        m  = shape_of(p.kind, p.rot);
        ok = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (shape_bit(m, 2'(r), 2'(c)) &&
                    (({1'b0, p.row} + 5'(r)) >= BOARD_ROWS ||
                     ({1'b0, p.col} + 5'(c)) >= BOARD_COLS))
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

endpackage

// File: hw/game_control.sv
module game_control import tetris_pkg::*; #(
    parameter int DROP_FRAMES = 30                    // Frames per gravity step
) (
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  cmd_e        cmd,
    output logic        cmd_ready,
    input  logic        frame_tick,
    output mover_op_e   op,
    output piece_kind_e spawn_kind,
    input  logic        fits,
    output logic        lock,
    input  logic        busy,
    output logic        game_over
);

    localparam int CNT_W = $clog2(DROP_FRAMES + 1);

    typedef enum logic [2:0] {IDLE, SPAWN, FALL, LOCK, CLEAR, OVER} state_e;

    state_e           state;
    state_e           state_nxt;
    logic [CNT_W-1:0] frame_cnt;                      // Ticks since last drop
    logic             drop_due;                       // Gravity step pending
    logic             cmd_fire;

    assign cmd_ready = (state == FALL) && !drop_due;  // Gravity has priority
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign lock      = (state == LOCK);
    assign game_over = (state == OVER);

    // Op to the mover
    always_comb begin
        op = OP_NONE;
        if (state == SPAWN) begin
            op = OP_SPAWN;
        end else if (state == FALL) begin
            if (drop_due) begin
                op = OP_DOWN;
            end else if (cmd_fire) begin
                case (cmd)
                    CMD_LEFT:  op = OP_LEFT;
                    CMD_RIGHT: op = OP_RIGHT;
                    CMD_ROT:   op = OP_ROT;
                    default:   op = OP_DOWN;
                endcase
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    state_nxt = SPAWN;
            SPAWN:   state_nxt = fits ? FALL : OVER;  // Blocked spawn ends the game
            FALL:    if (op == OP_DOWN && !fits) state_nxt = LOCK;
            LOCK:    state_nxt = CLEAR;
            CLEAR:   if (!busy) state_nxt = SPAWN;    // Row scan finished
            default: state_nxt = OVER;
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            spawn_kind <= PK_I;
        end else begin
            state <= state_nxt;
            if (state == SPAWN)                       // Step the fixed order
                spawn_kind <= (spawn_kind == PK_L) ? PK_I
                                                   : piece_kind_e'(3'(spawn_kind) + 3'd1);
        end
    end

    // Gravity timer, restarts with every piece
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            drop_due  <= 1'b0;
        end else if (state != FALL) begin
            frame_cnt <= '0;
            drop_due  <= 1'b0;
        end else begin
            if (drop_due)
                drop_due <= 1'b0;                     // Consumed this cycle
            if (frame_tick) begin
                if (frame_cnt == CNT_W'(DROP_FRAMES - 1)) begin
                    frame_cnt <= '0;
                    drop_due  <= 1'b1;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/pixel_render.sv
module pixel_render import tetris_pkg::*; #(
    parameter int CELL_SHIFT = 5                      // Cell is 2**CELL_SHIFT pixels square
) (
    input  logic         Clk,
    input  logic         rst_n,
    input  vga_beat_s    beat,
    input  board_t       board,
    input  piece_state_s piece,
    output vga_out_s     vga
);

    coord_t      cell_x;
    coord_t      cell_y;
    logic        in_field;
    logic        board_hit;
    board_t      piece_map;
    colour_t     colour;
    logic [23:0] rgb;

    assign cell_x    = beat.pos.x >> CELL_SHIFT;
    assign cell_y    = beat.pos.y >> CELL_SHIFT;
    assign in_field  = beat.active && cell_x < BOARD_COLS && cell_y < BOARD_ROWS;
    assign piece_map = piece_cells(piece);            // Falling piece as an overlay

    // Piece wins over the locked board
    always_comb begin
        colour    = '0;
        board_hit = 1'b0;
        if (in_field) begin
            if (piece_map[cell_y[3:0]][cell_x[3:0]])
                colour = colour_t'(piece.kind);
            else
                board_hit = board[cell_y[3:0]][cell_x[3:0]];
        end
    end

    // Palette
    always_comb begin
        case (colour)
            3'd1:    rgb = 24'h00FFFF;                // I cyan
            3'd2:    rgb = 24'hFFFF00;                // O yellow
            3'd3:    rgb = 24'hA000F0;                // T purple
            3'd4:    rgb = 24'h00FF00;                // S green
            3'd5:    rgb = 24'hFF0000;                // Z red
            3'd6:    rgb = 24'h0000FF;                // J blue
            3'd7:    rgb = 24'hFFA000;                // L orange
            default: rgb = 24'h000000;
        endcase
        if (board_hit)
            rgb = 24'hFFFFFF;                         // Locked cells are white
    end

    // Syncs ride the same register stage as the colour
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            vga.hs    <= 1'b1;
            vga.vs    <= 1'b1;
            vga.red   <= '0;
            vga.green <= '0;
            vga.blue  <= '0;
        end else begin
            vga.hs    <= beat.hs;
            vga.vs    <= beat.vs;
            vga.red   <= rgb[23:16];
            vga.green <= rgb[15:8];
            vga.blue  <= rgb[7:0];
        end
    end

endmodule

// File: hw/tetris_top.sv
module tetris_top import tetris_pkg::*; #(
    parameter int H_ACTIVE    = 640,
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33,
    parameter int CELL_SHIFT  = 5,                    // 32 pixel cells fill 512x480
    parameter int DROP_FRAMES = 30
) (
    input  logic         Clk,
    input  logic         rst_n,
    input  logic         cmd_valid,
    input  cmd_e         cmd,
    output logic         cmd_ready,
    output vga_out_s     vga,
    output piece_state_s piece_status,
    output logic [7:0]   lines_cleared,
    output logic         game_over
);

    mover_op_e   op;
    piece_kind_e spawn_kind;
    logic        fits;
    logic        lock;
    logic        busy;
    board_t      board;
    vga_beat_s   beat;
    logic        frame_tick;

    game_control #(.DROP_FRAMES(DROP_FRAMES)) game_control_i (
        .Clk, .rst_n, .cmd_valid, .cmd, .cmd_ready, .frame_tick,
        .op, .spawn_kind, .fits, .lock, .busy, .game_over
    );

    piece_mover piece_mover_i (
        .Clk, .rst_n, .op, .spawn_kind, .board, .fits,
        .piece (piece_status)                         // Falling piece goes straight out
    );

    playfield_store playfield_store_i (
        .Clk, .rst_n, .lock, .piece (piece_status), .board, .busy, .lines_cleared
    );

    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) vga_timing_i (
        .Clk, .rst_n, .beat, .frame_tick
    );

    pixel_render #(.CELL_SHIFT(CELL_SHIFT)) pixel_render_i (
        .Clk, .rst_n, .beat, .board, .piece (piece_status), .vga
    );

endmodule

// File: hw/vga_timing.sv
module vga_timing import tetris_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic      Clk,
    input  logic      rst_n,
    output vga_beat_s beat,
    output logic      frame_tick
);

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;     // First pixel of hsync
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;     // First line of vsync
    localparam int VS_END   = VS_START + V_SYNC;

    coord_t h_cnt;                                    // Pixel within line
    coord_t v_cnt;                                    // Line within frame
    logic   h_last;
    logic   v_last;

    assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;     // Wrap at end of frame
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Syncs are low inside their pulse window
    assign beat.hs     = !(h_cnt >= coord_t'(HS_START) && h_cnt < coord_t'(HS_END));
    assign beat.vs     = !(v_cnt >= coord_t'(VS_START) && v_cnt < coord_t'(VS_END));
    assign beat.active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
    assign beat.pos.x  = h_cnt;
    assign beat.pos.y  = v_cnt;

    // Single pulse on the first pixel of vsync
    assign frame_tick = (h_cnt == '0) && (v_cnt == coord_t'(VS_START));

endmodule

// File: piece/piece_mover.sv
module piece_mover import tetris_pkg::*; (
    input  logic         Clk,
    input  logic         rst_n,
    input  mover_op_e    op,
    input  piece_kind_e  spawn_kind,
    input  board_t       board,
    output logic         fits,
    output piece_state_s piece
);

    piece_state_s cand;                               // Piece after the requested op
    logic         at_wall;                            // Column step would wrap
    board_t       cand_cells;

    always_comb begin
        cand    = piece;
        at_wall = 1'b0;
        case (op)
            OP_SPAWN: begin
                cand.kind = spawn_kind;
                cand.rot  = '0;
                cand.col  = SPAWN_COL;
                cand.row  = '0;
            end
            OP_LEFT: begin
                at_wall  = (piece.col == '0);
                cand.col = piece.col - 1'b1;
            end
            OP_RIGHT: begin
                at_wall  = (piece.col == col_t'(BOARD_COLS - 1));
                cand.col = piece.col + 1'b1;
            end
            OP_ROT:  cand.rot = piece.rot + 1'b1;     // In place, no kicks
            OP_DOWN: cand.row = piece.row + 1'b1;
            default: ;
        endcase
    end

    // Inside the field and clear of locked cells
    assign cand_cells = piece_cells(cand);
    assign fits       = !at_wall && piece_inside(cand) && ((cand_cells & board) == '0);

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n)
            piece <= '{kind: PK_I, rot: '0, col: SPAWN_COL, row: '0};
        else if (op != OP_NONE && fits)               // Blocked moves leave it as is
            piece <= cand;
    end

endmodule

// File: playfield/playfield_store.sv
module playfield_store import tetris_pkg::*; (
    input  logic         Clk,
    input  logic         rst_n,
    input  logic         lock,
    input  piece_state_s piece,
    output board_t       board,
    output logic         busy,
    output logic [7:0]   lines_cleared
);

    row_t   scan_row;                                 // Row under test, bottom up
    logic   row_full;
    board_t shifted;                                  // Board with scan_row removed

    assign row_full = &board[scan_row];

    // Rows above the full one drop by one, top row empties
    always_comb begin
        shifted    = board;
        shifted[0] = '0;
        for (int i = 1; i < BOARD_ROWS; i++) begin
            if (row_t'(i) <= scan_row)
                shifted[i] = board[i-1];
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            board         <= '0;
            busy          <= 1'b0;
            scan_row      <= row_t'(BOARD_ROWS - 1);
            lines_cleared <= '0;
        end else if (lock) begin
            board    <= board | piece_cells(piece);   // Merge the landed piece
            busy     <= 1'b1;
            scan_row <= row_t'(BOARD_ROWS - 1);       // Start at the bottom
        end else if (busy) begin
            if (row_full) begin
                board <= shifted;                     // Same row is checked again
                if (lines_cleared != 8'hFF)
                    lines_cleared <= lines_cleared + 1'b1;
            end else if (scan_row == '0) begin
                busy <= 1'b0;                         // Top reached
            end else begin
                scan_row <= scan_row - 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module tetris_tb -f build.f -o tetris_sim || exit 1
out=$(./obj_dir/tetris_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed" && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

// File: verification/tetris_properties.sv
module tetris_properties import tetris_pkg::*; (
    input logic     Clk,
    input logic     rst_n,
    input logic     cmd_valid,
    input cmd_e     cmd,
    input logic     cmd_ready,
    input logic     lock,
    input logic     busy,
    input vga_out_s vga
);

    timeunit 1ns;
    timeprecision 1ps;

    cmd_hold: assert property (@(posedge Clk) disable iff (!rst_n)
        (cmd_valid && !cmd_ready) |=> $stable(cmd))
        else $error("cmd changed while waiting for cmd_ready");

    // No commands while a piece locks or rows are cleared
    ready_idle: assert property (@(posedge Clk) disable iff (!rst_n)
        cmd_ready |-> (!lock && !busy))
        else $error("cmd_ready high during lock or row scan");

    sync_blank: assert property (@(posedge Clk) disable iff (!rst_n)
        (!vga.hs || !vga.vs) |-> ({vga.red, vga.green, vga.blue} == 24'h0))
        else $error("colour driven during a sync pulse");

endmodule

bind tetris_top tetris_properties tetris_properties_i (
    .Clk (Clk), .rst_n (rst_n), .cmd_valid (cmd_valid), .cmd (cmd),
    .cmd_ready (cmd_ready), .lock (lock), .busy (busy), .vga (vga)
);

// File: verification/tetris_tb.sv
module tetris_tb import tetris_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CELL_SHIFT = 2;                    // 4x4 pixel cells
    localparam int H_TOTAL    = 64 + 4 + 8 + 4;       // Clocks per line
    localparam int V_TOTAL    = 60 + 2 + 2 + 2;       // Lines per frame
    localparam int FRAME      = H_TOTAL * V_TOTAL;    // Clocks per frame
    localparam int N_STEPS    = 24;

    typedef struct packed {
        cmd_e       cmd;
        logic [8:0] reps;                             // Times the command is sent
        logic [7:0] exp_lines;                        // Line count after the step
        logic       exp_over;
        logic       frame_chk;                        // Count lit pixels afterwards
    } step_s;

    localparam step_s STEPS [N_STEPS] = '{
        '{CMD_LEFT,  9'd7,   8'd0, 1'b0, 1'b0},       // I into the left wall
        '{CMD_RIGHT, 9'd13,  8'd0, 1'b0, 1'b0},       // Then the right wall
        '{CMD_ROT,   9'd1,   8'd0, 1'b0, 1'b0},
        '{CMD_RIGHT, 9'd4,   8'd0, 1'b0, 1'b0},       // Vertical I to column 15
        '{CMD_ROT,   9'd1,   8'd0, 1'b0, 1'b0},       // Blocked by the wall
        '{CMD_LEFT,  9'd3,   8'd0, 1'b0, 1'b0},
        '{CMD_ROT,   9'd3,   8'd0, 1'b0, 1'b0},       // Wraps to rotation 0
        '{CMD_DOWN,  9'd15,  8'd0, 1'b0, 1'b0},       // I locks at columns 12..15
        '{CMD_LEFT,  9'd6,   8'd0, 1'b0, 1'b1},
        '{CMD_DOWN,  9'd14,  8'd0, 1'b0, 1'b0},       // O at columns 0..1
        '{CMD_ROT,   9'd2,   8'd0, 1'b0, 1'b0},
        '{CMD_LEFT,  9'd4,   8'd0, 1'b0, 1'b0},
        '{CMD_DOWN,  9'd14,  8'd0, 1'b0, 1'b0},       // Flat T at columns 2..4
        '{CMD_RIGHT, 9'd4,   8'd0, 1'b0, 1'b0},
        '{CMD_DOWN,  9'd14,  8'd0, 1'b0, 1'b0},       // S leans on the I
        '{CMD_LEFT,  9'd2,   8'd0, 1'b0, 1'b0},
        '{CMD_DOWN,  9'd14,  8'd0, 1'b0, 1'b0},       // Z leans on the T
        '{CMD_RIGHT, 9'd1,   8'd0, 1'b0, 1'b0},
        '{CMD_DOWN,  9'd14,  8'd1, 1'b0, 1'b1},       // J completes the bottom row
        '{CMD_ROT,   9'd1,   8'd1, 1'b0, 1'b0},
        '{CMD_RIGHT, 9'd2,   8'd1, 1'b0, 1'b0},       // Upright L at column 8
        '{CMD_DOWN,  9'd12,  8'd1, 1'b0, 1'b0},
        '{CMD_LEFT,  9'd1,   8'd1, 1'b0, 1'b0},       // Blocked by a locked cell
        '{CMD_DOWN,  9'd300, 8'd1, 1'b1, 1'b0}        // Stack up at the spawn column
    };

    logic         Clk;
    logic         rst_n;
    logic         cmd_valid;
    cmd_e         cmd;
    logic         cmd_ready;
    vga_out_s     vga;
    piece_state_s piece_status;
    logic [7:0]   lines_cleared;
    logic         game_over;

    board_t       mboard;                             // Reference board
    piece_state_s mpiece;                             // Reference falling piece
    piece_kind_e  mnext;
    int           mlines;
    logic         mover;
    int           n_checks;
    int           n_errors;
    logic         ready_seen;

    tetris_top #(
        .H_ACTIVE (64), .H_FRONT (4), .H_SYNC (8), .H_BACK (4),
        .V_ACTIVE (60), .V_FRONT (2), .V_SYNC (2), .V_BACK (2),
        .CELL_SHIFT (CELL_SHIFT), .DROP_FRAMES (200)
    ) dut_i (
        .Clk, .rst_n, .cmd_valid, .cmd, .cmd_ready, .vga,
        .piece_status, .lines_cleared, .game_over
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    task automatic check_value(input string what, input int got, input int exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Every occupied cell inside the field and on an empty cell
    function automatic logic piece_fits(piece_kind_e k, rot_t rt, int col, int row);
        shape_mask_t m;
        logic        ok;
        m  = shape_of(k, rt);
        ok = 1'b1;
        for (int i = 0; i < 16; i++) begin
            if (m[15 - i]) begin
                if (row + i / 4 >= BOARD_ROWS || col + i % 4 < 0 || col + i % 4 >= BOARD_COLS)
                    ok = 1'b0;
                else if (mboard[row + i / 4][col + i % 4])
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic spawn_next();
        if (piece_fits(mnext, 2'd0, int'(SPAWN_COL), 0))
            mpiece = '{kind: mnext, rot: 2'd0, col: SPAWN_COL, row: 4'd0};
        else
            mover = 1'b1;                             // Old piece stays on show
        mnext = (mnext == PK_L) ? PK_I : piece_kind_e'(3'(mnext) + 3'd1);
    endtask

    task automatic lock_piece();
        shape_mask_t m;
        int          r;
        m = shape_of(mpiece.kind, mpiece.rot);
        for (int i = 0; i < 16; i++) begin
            if (m[15 - i])
                mboard[int'(mpiece.row) + i / 4][int'(mpiece.col) + i % 4] = 1'b1;
        end
        r = BOARD_ROWS - 1;
        while (r >= 0) begin                          // Bottom up, full row rechecked
            if (&mboard[r]) begin
                for (int i = r; i > 0; i--)
                    mboard[i] = mboard[i - 1];
                mboard[0] = '0;
                if (mlines < 255)
                    mlines++;
            end else begin
                r--;
            end
        end
        spawn_next();
    endtask

    task automatic apply_move(input cmd_e c);
        int   dc;
        int   dr;
        rot_t nr;
        dc = 0;
        dr = 0;
        nr = mpiece.rot;
        case (c)
            CMD_LEFT:  dc = -1;
            CMD_RIGHT: dc = 1;
            CMD_ROT:   nr = mpiece.rot + 2'd1;
            default:   dr = 1;
        endcase
        if (piece_fits(mpiece.kind, nr, int'(mpiece.col) + dc, int'(mpiece.row) + dr)) begin
            mpiece.rot = nr;
            mpiece.col = col_t'(int'(mpiece.col) + dc);
            mpiece.row = row_t'(int'(mpiece.row) + dr);
        end else if (c == CMD_DOWN) begin
            lock_piece();                             // Landed
        end
    endtask

    // Handshake, then wait out any lock and row scan
    task automatic send_cmd(input cmd_e c);
        @(posedge Clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(negedge Clk);
        while (!cmd_ready)
            @(negedge Clk);
        @(posedge Clk);                               // Transfer edge
        cmd_valid <= 1'b0;
        @(negedge Clk);
        while (!cmd_ready && !game_over)
            @(negedge Clk);
    endtask

    task automatic compare_state();
        check_value("piece state", int'(piece_status), int'(mpiece));
        check_value("lines cleared", int'(lines_cleared), mlines);
        check_value("game over", int'(game_over), int'(mover));
    endtask

    task automatic compare_board();
        for (int r = 0; r < BOARD_ROWS; r++)
            check_value($sformatf("board row %0d", r), int'(dut_i.board[r]), int'(mboard[r]));
    endtask

    // Any FRAME consecutive clocks cover every pixel once
    task automatic check_frame();
        int lit;
        int cells;
        int hs_low;
        int vs_low;
        lit    = 0;
        hs_low = 0;
        vs_low = 0;
        cells  = 4;                                   // Falling piece
        for (int r = 0; r < BOARD_ROWS; r++)
            cells += $countones(mboard[r]);
        for (int i = 0; i < FRAME; i++) begin
            @(negedge Clk);
            if ({vga.red, vga.green, vga.blue} != 24'h0)
                lit++;
            if (!vga.hs)
                hs_low++;
            if (!vga.vs)
                vs_low++;
        end
        check_value("lit pixels in a frame", lit, cells << (2 * CELL_SHIFT));
        check_value("hsync clocks in a frame", hs_low, 8 * V_TOTAL);   // 8 clocks every line
        check_value("vsync clocks in a frame", vs_low, 2 * H_TOTAL);   // Two whole lines
    endtask

    initial begin
        int total_reps;
        total_reps = 0;
        for (int i = 0; i < N_STEPS; i++)
            total_reps += int'(STEPS[i].reps);
        #((total_reps * 40 + 3 * FRAME + 1000) * 20);
        $display("Watchdog expired, the DUT stopped answering");
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = CMD_LEFT;
        n_checks   = 0;
        n_errors   = 0;
        ready_seen = 1'b0;
        mboard     = '0;
        mlines     = 0;
        mover      = 1'b0;
        mnext      = PK_I;
        spawn_next();                                 // First piece after reset
        repeat (3) @(posedge Clk);
        rst_n <= 1'b1;
        @(negedge Clk);
        while (!cmd_ready)
            @(negedge Clk);
        compare_state();
        for (int s = 0; s < N_STEPS; s++) begin
            for (int n = 0; n < int'(STEPS[s].reps); n++) begin
                if (game_over || mover)
                    break;
                send_cmd(STEPS[s].cmd);
                apply_move(STEPS[s].cmd);
                compare_state();
            end
            check_value("lines vs table", int'(lines_cleared), int'(STEPS[s].exp_lines));
            check_value("game over vs table", int'(game_over), int'(STEPS[s].exp_over));
            compare_board();
            if (STEPS[s].frame_chk)
                check_frame();
        end
        repeat (200) begin                            // No commands once the game is over
            @(negedge Clk);
            ready_seen = ready_seen | cmd_ready;
        end
        check_value("cmd_ready after game over", int'(ready_seen), 0);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
